//--- Bender.yml
package:
  name: keystone

sources:
  - verilog/keystone_pkg.sv
  - verilog/keystone_regs.sv
  - verilog/keystone_ctrl.sv
  - verilog/homography_mac.sv
  - verilog/coord_divider.sv
  - verilog/source_buffer.sv
  - verilog/keystone_top.sv
  - target: simulation
    files:
      - sim/keystone_tb.sv

//--- flist.f
verilog/keystone_pkg.sv
verilog/keystone_regs.sv
verilog/keystone_ctrl.sv
verilog/homography_mac.sv
verilog/coord_divider.sv
verilog/source_buffer.sv
verilog/keystone_top.sv
sim/keystone_tb.sv

//--- sim/keystone_tb.sv
// Keystone engine testbench driving APB and pixel ports against a software homography model
module keystone_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import keystone_pkg::*;

    localparam int WIDTH = 16;
    localparam int HEIGHT = 8;
    localparam int PIXELS = WIDTH * HEIGHT;
    localparam int NUM_ROWS = 4;
    // Table rows plus the two passes of the late coefficient write
    localparam int PASSES = NUM_ROWS + 2;
    localparam int LIMIT = PASSES * PIXELS * (DIV_STEPS + 12) + 2 * PIXELS + 1000;

    logic clock;
    logic reset;
    logic [5:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [PIXEL_W-1:0] pixel_in;
    logic pixel_in_valid;
    logic pixel_in_ready;
    logic [PIXEL_W-1:0] pixel_out;
    logic pixel_out_valid;
    logic pixel_out_ready;

    logic [31:0] lcg_state = 32'h5001_ea8f;
    logic [PIXEL_W-1:0] src [PIXELS];
    logic [PIXEL_W-1:0] got [PIXELS];
    logic [PIXEL_W-1:0] saved [PIXELS];
    int cur_h [NUM_COEFS];
    int cycles = 0;
    int passes = 0;
    logic last_err;

    ////////////////////////////////////////
    // Test table
    ////////////////////////////////////////

    string test_name [NUM_ROWS] = '{"identity", "shift", "keystone", "keystone_bp"};
    // H11 H12 H13 H21 H22 H23 H31 H32
    int table_h [NUM_ROWS][NUM_COEFS] = '{
        '{ONE, 0, 0, 0, ONE, 0, 0, 0},
        '{ONE, 0, 3 * ONE, 0, ONE, 0, 0, 0},
        // w goes negative toward the top left corner
        '{ONE + 16, 8, ONE / 2, -6, ONE, -40, 24, 20},
        '{ONE + 16, 8, ONE / 2, -6, ONE, -40, 24, 20}
    };
    // Same coefficients as the row before, sink stalls at random
    bit back_pressure [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1};

    keystone_top #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) keystone_top_inst (
        .clock, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .pixel_in, .pixel_in_valid, .pixel_in_ready,
        .pixel_out, .pixel_out_valid, .pixel_out_ready
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Run limit sized from the pass count
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("TIMEOUT: run did not finish within %0d cycles", LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Truncating divide of num << FRAC_BITS, then round half away from zero
    function automatic longint round_div(input longint num, input longint den);
        longint mag;
        longint q;
        longint r;
        mag = (num < 0) ? -num : num;
        q = (mag << FRAC_BITS) / den;
        r = (q >> FRAC_BITS) + ((q >> (FRAC_BITS - 1)) & 1);
        return (num < 0) ? -r : r;
    endfunction

    function automatic logic [PIXEL_W-1:0] model_pixel(input int dx, input int dy);
        longint xc;
        longint yc;
        longint xw;
        longint yw;
        longint wsum;
        longint sx;
        longint sy;
        xc = dx - WIDTH / 2;
        yc = dy - HEIGHT / 2;
        xw = cur_h[0] * xc + cur_h[1] * yc + cur_h[2];
        yw = cur_h[3] * xc + cur_h[4] * yc + cur_h[5];
        wsum = cur_h[6] * xc + cur_h[7] * yc + longint'(ONE);
        if (wsum <= 0)
            return FILL_COLOR;
        sx = round_div(xw, wsum) + WIDTH / 2;
        sy = round_div(yw, wsum) + HEIGHT / 2;
        if (sx < 0 || sx >= WIDTH || sy < 0 || sy >= HEIGHT)
            return FILL_COLOR;
        return src[int'(sy) * WIDTH + int'(sx)];
    endfunction

    // Setup on one falling edge, access on the next, sampled mid-phase
    task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
        @(negedge clock);
        psel = 1'b1;
        pwrite = 1'b1;
        penable = 1'b0;
        paddr = addr;
        pwdata = data;
        @(negedge clock);
        penable = 1'b1;
        #2;
        last_err = pslverr;
        check_value("pready in write access", 32'd1, 32'(pready));
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [5:0] addr, output logic [31:0] data);
        @(negedge clock);
        psel = 1'b1;
        pwrite = 1'b0;
        penable = 1'b0;
        paddr = addr;
        @(negedge clock);
        penable = 1'b1;
        #2;
        data = prdata;
        last_err = pslverr;
        check_value("pready in read access", 32'd1, 32'(pready));
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_coefs();
        for (int i = 0; i < NUM_COEFS; i++)
            apb_write(6'(int'(COEF_H11) + 4 * i), 32'(cur_h[i]));
    endtask

    task automatic check_idle_status();
        logic [31:0] data;
        apb_read(STATUS, data);
        check_value("status busy after pass", 32'd0, 32'(data[0]));
        check_value("status pass count", 32'(passes & 255), 32'(data[15:8]));
    endtask

    task automatic load_frame();
        int idx;
        idx = 0;
        apb_write(CTRL, 32'h1);
        while (idx < PIXELS) begin
            @(negedge clock);
            if (pixel_in_ready) begin
                pixel_in = src[idx];
                pixel_in_valid = 1'b1;
                idx++;
            end else begin
                pixel_in_valid = 1'b0;
            end
        end
        @(negedge clock);
        pixel_in_valid = 1'b0;
        check_value("pixel_in_ready low after load", 32'd0, 32'(pixel_in_ready));
    endtask

    // Start a pass and collect every output pixel
    task automatic run_pass(input bit bp);
        logic [31:0] rnd;
        logic ready;
        logic stalled;
        logic [PIXEL_W-1:0] held;
        int count;
        count = 0;
        stalled = 1'b0;
        held = '0;
        apb_write(CTRL, 32'h2);
        while (count < PIXELS) begin
            @(negedge clock);
            rnd = next_rand();
            ready = bp ? rnd[20] : 1'b1;
            // A stalled pixel stays valid and unchanged
            if (stalled) begin
                check_value("valid held in stall", 32'd1, 32'(pixel_out_valid));
                check_value("pixel held in stall", 32'(held), 32'(pixel_out));
            end
            pixel_out_ready = ready;
            if (pixel_out_valid && ready) begin
                got[count] = pixel_out;
                count++;
            end
            stalled = pixel_out_valid & ~ready;
            held = pixel_out;
        end
        @(negedge clock);
        pixel_out_ready = 1'b0;
        passes++;
    endtask

    task automatic check_pixels(input string name);
        for (int i = 0; i < PIXELS; i++)
            check_value($sformatf("%s (%0d,%0d)", name, i % WIDTH, i / WIDTH),
                        32'(model_pixel(i % WIDTH, i / WIDTH)), 32'(got[i]));
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] data;
        logic [31:0] rnd;
        reset = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        pixel_in = '0;
        pixel_in_valid = 1'b0;
        pixel_out_ready = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        check_value("pixel_in_ready after reset", 32'd0, 32'(pixel_in_ready));
        check_value("pixel_out_valid after reset", 32'd0, 32'(pixel_out_valid));
        check_value("pslverr after reset", 32'd0, 32'(pslverr));
        check_idle_status();

        for (int i = 0; i < PIXELS; i++) begin
            rnd = next_rand();
            src[i] = rnd[31:8];
        end
        load_frame();

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < NUM_COEFS; i++)
                cur_h[i] = table_h[r][i];
            write_coefs();
            run_pass(back_pressure[r]);
            check_pixels(test_name[r]);
            if (r == 0) begin
                for (int i = 0; i < PIXELS; i++)
                    check_value($sformatf("identity copy %0d", i), 32'(src[i]), 32'(got[i]));
            end
            if (back_pressure[r]) begin
                for (int i = 0; i < PIXELS; i++)
                    check_value($sformatf("%s vs free run %0d", test_name[r], i),
                                32'(saved[i]), 32'(got[i]));
            end
            saved = got;
            check_idle_status();
        end

        // Coefficient write mid-pass lands on the following pass
        for (int i = 0; i < NUM_COEFS; i++)
            cur_h[i] = table_h[0][i];
        write_coefs();
        fork
            run_pass(1'b0);
            begin
                repeat (40) @(negedge clock);
                apb_write(COEF_H13, 32'(3 * ONE));
                apb_read(STATUS, data);
                check_value("status busy in pass", 32'd1, 32'(data[0]));
                check_value("pass count in pass", 32'(passes & 255), 32'(data[15:8]));
            end
        join
        check_pixels("late write same pass");
        check_idle_status();
        cur_h[2] = 3 * ONE;
        run_pass(1'b0);
        check_pixels("late write next pass");
        check_idle_status();

        // Unmapped addresses and coefficient readback
        apb_write(6'h28, 32'h1);
        check_value("unmapped write pslverr", 32'd1, 32'(last_err));
        apb_read(6'h3C, data);
        check_value("unmapped read pslverr", 32'd1, 32'(last_err));
        apb_write(COEF_H12, 32'h0000_FFFB);
        apb_read(COEF_H12, data);
        check_value("coef readback negative", 32'hFFFF_FFFB, data);
        check_value("mapped read pslverr", 32'd0, 32'(last_err));
        apb_read(COEF_H11, data);
        check_value("coef readback H11", 32'(ONE), data);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- verilog/coord_divider.sv
// Sequential divider pair normalising xw and yw by w into rounded source coordinates
module coord_divider #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic div_start,
    input  logic signed [keystone_pkg::ACC_W-1:0] xw,
    input  logic signed [keystone_pkg::ACC_W-1:0] yw,
    input  logic signed [keystone_pkg::ACC_W-1:0] w,
    output logic div_done,
    output logic signed [keystone_pkg::COORD_W-1:0] src_x,
    output logic signed [keystone_pkg::COORD_W-1:0] src_y,
    output logic src_valid
);
    import keystone_pkg::*;

    localparam int CNT_W = $clog2(DIV_STEPS + 1);
    localparam int INT_W = QUOT_W - FRAC_BITS;

    // Lane 0 is x, lane 1 is y
    logic signed [ACC_W-1:0] num [2];
    logic [ACC_W-1:0]  mag [2];
    logic [ACC_W-1:0]  hi [2];
    logic [ACC_W-1:0]  shifted [2];
    logic              fits [2];
    logic [ACC_W-1:0]  rem [2];
    logic [QUOT_W-1:0] dq [2];
    logic              neg [2];
    logic              ovf [2];
    logic [ACC_W-1:0]  divisor;
    logic [CNT_W-1:0]  count;
    logic              w_ok;

    // Round half away from zero, recentre, and push anything unrepresentable off-frame
    function automatic logic signed [COORD_W-1:0] to_coord(
        input logic [QUOT_W-1:0] q,
        input logic sign,
        input logic over,
        input int centre
    );
        logic [INT_W:0]          imag;
        logic signed [INT_W+1:0] val;
        imag = q[QUOT_W-1:FRAC_BITS] + q[FRAC_BITS-1];
        val = sign ? -$signed({1'b0, imag}) : $signed({1'b0, imag});
        val = val + (INT_W + 2)'(centre);
        if (over || val < -(2 ** (COORD_W - 1)) || val >= 2 ** (COORD_W - 1))
            return {1'b1, {(COORD_W-1){1'b0}}};
        return val[COORD_W-1:0];
    endfunction

    ////////////////////////////////////////
    // Restoring step, both lanes
    ////////////////////////////////////////

    always_comb begin
        num[0] = xw;
        num[1] = yw;
        for (int i = 0; i < 2; i++) begin
            // Sign-magnitude, so the quotient truncates toward zero
            mag[i] = num[i][ACC_W-1] ? ACC_W'(-num[i]) : ACC_W'(num[i]);
            // Dividend is mag << FRAC_BITS, its bits above the quotient seed the remainder
            hi[i] = mag[i] >> INT_W;
            shifted[i] = {rem[i][ACC_W-2:0], dq[i][QUOT_W-1]};
            fits[i] = shifted[i] >= divisor;
        end
    end

    always_ff @(posedge clock) begin
        if (div_start) begin
            divisor <= ACC_W'(w);
        end
        for (int i = 0; i < 2; i++) begin
            if (div_start) begin
                neg[i] <= num[i][ACC_W-1];
                // quotient would not fit in QUOT_W bits
                ovf[i] <= hi[i] >= ACC_W'(w);
                rem[i] <= hi[i];
                dq[i] <= {mag[i][INT_W-1:0], {FRAC_BITS{1'b0}}};
            end else if (count != '0 && w_ok) begin
                // Dividend bits shift out the top, quotient bits shift in below
                rem[i] <= fits[i] ? shifted[i] - divisor : shifted[i];
                dq[i] <= {dq[i][QUOT_W-2:0], fits[i]};
            end
        end
    end

    ////////////////////////////////////////
    // Step counter and done
    ////////////////////////////////////////

    // Counter runs even for w <= 0 to keep done timing fixed
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
            div_done <= 1'b0;
            w_ok <= 1'b0;
        end else begin
            div_done <= (count == CNT_W'(1));
            if (div_start) begin
                count <= CNT_W'(DIV_STEPS);
                w_ok <= (w > 0);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    assign src_x = to_coord(dq[0], neg[0], ovf[0], WIDTH / 2);
    assign src_y = to_coord(dq[1], neg[1], ovf[1], HEIGHT / 2);
    assign src_valid = w_ok;

endmodule

//--- verilog/homography_mac.sv
// Homography multiply-accumulate forming xw, yw and w for a centred destination point
module homography_mac #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic issue,
    input  logic signed [keystone_pkg::COORD_W-1:0] dest_x,
    input  logic signed [keystone_pkg::COORD_W-1:0] dest_y,
    input  logic signed [keystone_pkg::COEF_W-1:0]  coefs [keystone_pkg::NUM_COEFS],
    output logic signed [keystone_pkg::ACC_W-1:0]   xw,
    output logic signed [keystone_pkg::ACC_W-1:0]   yw,
    output logic signed [keystone_pkg::ACC_W-1:0]   w
);
    import keystone_pkg::*;

    logic signed [COORD_W-1:0] xc;
    logic signed [COORD_W-1:0] yc;
    logic signed [ACC_W-1:0]   xw_sum;
    logic signed [ACC_W-1:0]   yw_sum;
    logic signed [ACC_W-1:0]   w_sum;

    // Origin moved to the frame centre
    assign xc = dest_x - COORD_W'(WIDTH / 2);
    assign yc = dest_y - COORD_W'(HEIGHT / 2);

    // Products keep FRAC_BITS fraction bits, same as the constant terms
    always_comb begin
        xw_sum = coefs[0] * xc + coefs[1] * yc + coefs[2];
        yw_sum = coefs[3] * xc + coefs[4] * yc + coefs[5];
        // H33 fixed at 1.0
        w_sum = coefs[6] * xc + coefs[7] * yc + ONE;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            xw <= '0;
            yw <= '0;
            w <= '0;
        end else if (issue) begin
            xw <= xw_sum;
            yw <= yw_sum;
            w <= w_sum;
        end
    end

endmodule

//--- verilog/keystone_ctrl.sv
// Keystone controller FSM with raster counters for frame load and pixel sequencing
module keystone_ctrl #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic load_start,
    input  logic run_start,
    input  logic pixel_in_valid,
    output logic pixel_in_ready,
    input  logic pixel_out_ready,
    output logic pixel_out_valid,
    output logic write_en,
    output logic signed [keystone_pkg::COORD_W-1:0] write_x,
    output logic signed [keystone_pkg::COORD_W-1:0] write_y,
    output logic issue,
    output logic signed [keystone_pkg::COORD_W-1:0] dest_x,
    output logic signed [keystone_pkg::COORD_W-1:0] dest_y,
    output logic div_start,
    input  logic div_done,
    output logic read_en,
    output logic busy,
    output logic pass_done
);
    import keystone_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic signed [COORD_W-1:0] x_cnt;
    logic signed [COORD_W-1:0] y_cnt;
    logic step;
    logic last;

    ////////////////////////////////////////
    // Raster counters
    ////////////////////////////////////////

    // One counter pair serves the load and the pass, both raster order
    assign last = (x_cnt == COORD_W'(WIDTH - 1)) && (y_cnt == COORD_W'(HEIGHT - 1));
    assign step = write_en | (pixel_out_valid & pixel_out_ready);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (step) begin
            if (x_cnt == COORD_W'(WIDTH - 1)) begin
                x_cnt <= '0;
                // Wraps to zero after the last row, ready for the next frame
                y_cnt <= (y_cnt == COORD_W'(HEIGHT - 1)) ? '0 : y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    assign write_x = x_cnt;
    assign write_y = y_cnt;
    assign dest_x = x_cnt;
    assign dest_y = y_cnt;

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (load_start) state_next = LOAD;
                      else if (run_start) state_next = ISSUE;
            LOAD:     if (write_en && last) state_next = IDLE;
            ISSUE:    state_next = WAIT_DIV;
            WAIT_DIV: if (div_done) state_next = READ;
            READ:     state_next = EMIT;
            EMIT:     if (pixel_out_ready) state_next = last ? IDLE : ISSUE;
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            div_start <= 1'b0;
        end else begin
            state <= state_next;
            // Sums land one cycle after issue, divider starts then
            div_start <= issue;
        end
    end

    assign pixel_in_ready = (state == LOAD);
    assign write_en = pixel_in_ready & pixel_in_valid;
    assign issue = (state == ISSUE);
    assign read_en = (state == READ);
    assign pixel_out_valid = (state == EMIT);
    assign busy = (state != IDLE);
    // Last destination pixel taken by the sink
    assign pass_done = pixel_out_valid & pixel_out_ready & last;

    // Divider answers only the request in flight
    assert property (@(posedge clock) disable iff (reset) div_done |-> state == WAIT_DIV);

endmodule

//--- verilog/keystone_pkg.sv
// Keystone correction shared widths, fixed-point constants and enums
package keystone_pkg;

    ////////////////////////////////////////
    // Fixed-point formats
    ////////////////////////////////////////

    // Coefficients are signed with FRAC_BITS fraction bits
    localparam int COEF_W = 16;
    localparam int FRAC_BITS = 8;
    localparam logic signed [COEF_W-1:0] ONE = COEF_W'(1 << FRAC_BITS);

    // Pixel coordinates, signed so centred values fit
    localparam int COORD_W = 12;

    // Homogeneous sums and divider sizing
    localparam int ACC_W = 32;
    localparam int QUOT_W = 24;
    // One quotient bit per iteration
    localparam int DIV_STEPS = QUOT_W;

    ////////////////////////////////////////
    // Pixels and registers
    ////////////////////////////////////////

    localparam int PIXEL_W = 24;
    // Pink, emitted for any point with no source pixel
    localparam logic [PIXEL_W-1:0] FILL_COLOR = 24'hFF1EA6;

    // H11 H12 H13 H21 H22 H23 H31 H32, in that order
    localparam int NUM_COEFS = 8;

    // APB word addresses
    typedef enum logic [5:0] {
        CTRL     = 6'h00,
        STATUS   = 6'h04,
        COEF_H11 = 6'h08,
        COEF_H12 = 6'h0C,
        COEF_H13 = 6'h10,
        COEF_H21 = 6'h14,
        COEF_H22 = 6'h18,
        COEF_H23 = 6'h1C,
        COEF_H31 = 6'h20,
        COEF_H32 = 6'h24
    } reg_addr_e;

    typedef enum logic [2:0] {IDLE, LOAD, ISSUE, WAIT_DIV, READ, EMIT} ctrl_state_e;

endpackage

//--- verilog/keystone_regs.sv
// Keystone APB register block with control, status and the per-pass coefficient latch
module keystone_regs (
    input  logic        clock,
    input  logic        reset,
    input  logic [5:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        busy,
    input  logic        pass_done,
    output logic        load_start,
    output logic        run_start,
    output logic signed [keystone_pkg::COEF_W-1:0] coefs [keystone_pkg::NUM_COEFS]
);
    import keystone_pkg::*;

    localparam int IDX_W = $clog2(NUM_COEFS);

    logic signed [COEF_W-1:0] sw_coefs [NUM_COEFS];
    logic [7:0]       pass_count;
    logic             access;
    logic             wr;
    logic             known;
    logic             is_coef;
    logic [IDX_W-1:0] coef_idx;
    reg_addr_e        addr;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign addr = reg_addr_e'(paddr);
    assign access = psel & penable;
    assign wr = access & pwrite;
    // Coefficient words start at 0x08, one per word
    assign coef_idx = IDX_W'(paddr[5:2] - 4'd2);

    always_comb begin
        known = 1'b1;
        is_coef = 1'b0;
        case (addr)
            CTRL, STATUS: known = 1'b1;
            COEF_H11, COEF_H12, COEF_H13, COEF_H21,
            COEF_H22, COEF_H23, COEF_H31, COEF_H32: is_coef = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // Zero wait states
    assign pready = 1'b1;
    assign pslverr = access & ~known;

    // Start pulses, only taken while the engine is idle
    assign load_start = wr && addr == CTRL && !busy && pwdata[0];
    // A load request wins over a pass request in the same write
    assign run_start = wr && addr == CTRL && !busy && pwdata[1] && !pwdata[0];

    always_comb begin
        prdata = '0;
        if (addr == STATUS)
            prdata = {16'h0000, pass_count, 7'h00, busy};
        else if (is_coef)
            prdata = {{(32-COEF_W){sw_coefs[coef_idx][COEF_W-1]}}, sw_coefs[coef_idx]};
    end

    ////////////////////////////////////////
    // Coefficients and pass counter
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_COEFS; i++) begin
                sw_coefs[i] <= '0;
                coefs[i] <= '0;
            end
            pass_count <= '0;
        end else begin
            if (wr && is_coef)
                sw_coefs[coef_idx] <= pwdata[COEF_W-1:0];
            // Working set only moves at the start of a pass
            if (run_start)
                coefs <= sw_coefs;
            if (pass_done)
                pass_count <= pass_count + 8'd1;
        end
    end

    // Bus master must hold psel through the access phase
    assert property (@(posedge clock) disable iff (reset) penable |-> psel);

endmodule

//--- verilog/keystone_top.sv
// Keystone correction engine top level joining APB registers, controller and datapath
module keystone_top #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  logic        clock,
    input  logic        reset,
    input  logic [5:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic [keystone_pkg::PIXEL_W-1:0] pixel_in,
    input  logic        pixel_in_valid,
    output logic        pixel_in_ready,
    output logic [keystone_pkg::PIXEL_W-1:0] pixel_out,
    output logic        pixel_out_valid,
    input  logic        pixel_out_ready
);
    import keystone_pkg::*;

    ////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////

    logic load_start;
    logic run_start;
    logic busy;
    logic pass_done;
    logic signed [COEF_W-1:0] coefs [NUM_COEFS];

    // Frame load and raster position
    logic write_en;
    logic signed [COORD_W-1:0] write_x;
    logic signed [COORD_W-1:0] write_y;
    logic issue;
    logic signed [COORD_W-1:0] dest_x;
    logic signed [COORD_W-1:0] dest_y;

    // Transform and normalise
    logic signed [ACC_W-1:0] xw;
    logic signed [ACC_W-1:0] yw;
    logic signed [ACC_W-1:0] w;
    logic div_start;
    logic div_done;
    logic signed [COORD_W-1:0] src_x;
    logic signed [COORD_W-1:0] src_y;
    logic src_valid;
    logic read_en;

    keystone_regs regs_inst (
        .clock, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .busy, .pass_done,
        .load_start, .run_start, .coefs
    );

    keystone_ctrl #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) ctrl_inst (
        .clock, .reset, .load_start, .run_start,
        .pixel_in_valid, .pixel_in_ready, .pixel_out_ready, .pixel_out_valid,
        .write_en, .write_x, .write_y, .issue, .dest_x, .dest_y,
        .div_start, .div_done, .read_en, .busy, .pass_done
    );

    homography_mac #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) mac_inst (
        .clock, .reset, .issue, .dest_x, .dest_y, .coefs, .xw, .yw, .w
    );

    coord_divider #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) div_inst (
        .clock, .reset, .div_start, .xw, .yw, .w,
        .div_done, .src_x, .src_y, .src_valid
    );

    source_buffer #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) buffer_inst (
        .clock, .write_en, .write_x, .write_y, .pixel_in,
        .read_en, .src_x, .src_y, .src_valid, .pixel_out
    );

endmodule

//--- verilog/source_buffer.sv
// Source frame memory with raster write port and bounds-checked registered read
module source_buffer #(
    parameter int WIDTH  = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic write_en,
    input  logic signed [keystone_pkg::COORD_W-1:0] write_x,
    input  logic signed [keystone_pkg::COORD_W-1:0] write_y,
    input  logic [keystone_pkg::PIXEL_W-1:0]        pixel_in,
    input  logic read_en,
    input  logic signed [keystone_pkg::COORD_W-1:0] src_x,
    input  logic signed [keystone_pkg::COORD_W-1:0] src_y,
    input  logic src_valid,
    output logic [keystone_pkg::PIXEL_W-1:0]        pixel_out
);
    import keystone_pkg::*;

    localparam int DEPTH  = WIDTH * HEIGHT;
    localparam int ADDR_W = $clog2(DEPTH);

    logic [PIXEL_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0]  waddr;
    logic [ADDR_W-1:0]  raddr;
    logic               in_frame;

    // Row-major, one word per pixel
    assign waddr = ADDR_W'(write_y * WIDTH + write_x);
    assign raddr = ADDR_W'(src_y * WIDTH + src_x);

    // Negative w or a point off the frame has no source pixel
    assign in_frame = src_valid && src_x >= 0 && src_x < WIDTH
                      && src_y >= 0 && src_y < HEIGHT;

    always_ff @(posedge clock) begin
        if (write_en)
            mem[waddr] <= pixel_in;
    end

    // Held between reads, so the output stays stable while the sink stalls
    always_ff @(posedge clock) begin
        if (read_en)
            pixel_out <= in_frame ? mem[raddr] : FILL_COLOR;
    end

endmodule
